// File: current_mixer.sv
`timescale 1ns/1ps

module current_mixer (
    input  logic                    neuron_clk,
    input  logic                    reset_sim,
    input  neuron_pkg::float_word_t f_scaled,
    input  neuron_pkg::float_word_t f_noise,
    output logic signed [31:0]      i_current
);
    import neuron_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Noisy rate, float domain
    //////////////////////////////////////////////////////////////////////

    float_word_t mix_prod;

    // Rate times noise factor in [1,2)
    float_mult u_mult (
        .x       (f_scaled),
        .y       (f_noise),
        .product (mix_prod)
    );

    //////////////////////////////////////////////////////////////////////
    // Integer synaptic current
    //////////////////////////////////////////////////////////////////////

    logic signed [31:0] cur_floor;

    float_floor u_floor (
        .f_in  (mix_prod),
        .i_out (cur_floor)
    );

    // Second pipeline stage
    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            i_current <= 32'sd0;
        end else begin
            i_current <= cur_floor;
        end
    end

endmodule

// File: files.f
+incdir+.
neuron_pkg.sv
float_mult.sv
float_floor.sv
lfsr_noise.sv
pps_scaler.sv
current_mixer.sv
izneuron.sv
neuron_pool.sv
tb_clock.sv
neuron_pool_tb.sv

// File: float_floor.sv
`timescale 1ns/1ps

module float_floor (
    input  neuron_pkg::float_word_t f_in,
    output logic signed [31:0]      i_out
);
    import neuron_pkg::*;

    float_fields_t fin;
    // Significand with hidden one
    logic [23:0]   sig;
    // Unbiased exponent, 0..30 in the normal range
    logic [4:0]    shamt;
    // Integer part in [54:23], fraction in [22:0]
    logic [54:0]   shifted;
    logic [31:0]   mag;
    logic          frac_nz;

    always_comb begin
        fin     = f_in.f;
        sig     = {1'b1, fin.mant};
        shamt   = 5'(fin.exp - 8'd127);
        shifted = {31'd0, sig} << shamt;
        mag     = shifted[54:23];
        frac_nz = |shifted[22:0];

        if (fin.exp == 8'd0) begin
            // Exponent zero reads as zero
            i_out = 32'sd0;
        end else if (fin.exp < 8'd127) begin
            // Magnitude below one
            i_out = fin.sign ? -32'sd1 : 32'sd0;
        end else if (fin.exp >= 8'd158) begin
            // 2^31 and up clips to the int32 limits
            i_out = fin.sign ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
        end else if (fin.sign) begin
            // Negative with fraction rounds one further down
            i_out = -$signed(mag) - $signed({31'd0, frac_nz});
        end else begin
            i_out = $signed(mag);
        end
    end

endmodule

// File: float_mult.sv
`timescale 1ns/1ps

module float_mult (
    input  neuron_pkg::float_word_t x,
    input  neuron_pkg::float_word_t y,
    output neuron_pkg::float_word_t product
);
    import neuron_pkg::*;

    // Significands with hidden one restored
    logic [23:0] sig_x;
    logic [23:0] sig_y;
    // Full 48-bit significand product
    logic [47:0] sig_prod;
    // Product in [2,4) needs one bit of normalisation
    logic        norm;
    logic [22:0] mant_res;
    // Biased exponent sum, wide enough for 255 + 255 + 1
    logic [9:0]  exp_sum;
    float_word_t res;

    always_comb begin
        sig_x    = {1'b1, x.f.mant};
        sig_y    = {1'b1, y.f.mant};
        sig_prod = sig_x * sig_y;
        norm     = sig_prod[47];

        // Drop the leading one, truncate the rest
        if (norm) begin
            mant_res = sig_prod[46:24];
        end else begin
            mant_res = sig_prod[45:23];
        end

        exp_sum = {2'b00, x.f.exp} + {2'b00, y.f.exp} + {9'd0, norm};

        res.bits = 32'd0;
        if (x.f.exp == 8'd0 || y.f.exp == 8'd0) begin
            // Zero operand
            res.bits = 32'd0;
        end else if (exp_sum <= 10'd127) begin
            // Underflow flushes to zero
            res.bits = 32'd0;
        end else begin
            res.f.sign = x.f.sign ^ y.f.sign;
            // Remove one bias; overflow simply wraps
            res.f.exp  = 8'(exp_sum - 10'd127);
            res.f.mant = mant_res;
        end
    end

    assign product = res;

endmodule

// File: izneuron.sv
`timescale 1ns/1ps
`include "neuron_consts.svh"

module izneuron (
    input  logic                      neuron_clk,
    input  logic                      reset_sim,
    input  logic signed [31:0]        i_current,
    output neuron_pkg::spike_out_t    spike_info,
    output neuron_pkg::neuron_state_t state_out
);
    import neuron_pkg::*;

    // 140 mV/ms offset in Q8
    localparam logic signed [47:0] DV_CONST = 48'sd140 <<< `NEURON_FRAC;
    // Input current limit
    localparam logic signed [31:0] I_LIMIT  = 32'sd1000;
    // 18-bit signed range for v
    localparam logic signed [47:0] V_MAX    = 48'sd131071;
    localparam logic signed [47:0] V_MIN    = -48'sd131072;

    neuron_state_t state_q;
    neuron_state_t state_next;
    spike_out_t    spike_q;

    // Wide working copies
    logic signed [47:0] v_w;
    logic signed [47:0] u_w;
    logic signed [47:0] q_w;
    logic signed [47:0] quad_w;
    logic signed [31:0] i_clamp;
    logic signed [47:0] dv_w;
    logic signed [47:0] du_w;
    logic signed [47:0] v_new;
    logic signed [47:0] u_new;
    logic signed [17:0] v_sat;
    logic               fire;

    always_comb begin
        v_w = 48'(state_q.v_mem);
        u_w = 48'(state_q.u_rec);

        // 0.04 v^2 as v^2/32 + v^2/128, back to Q8
        q_w    = (v_w * v_w) >>> `NEURON_FRAC;
        quad_w = (q_w >>> 5) + (q_w >>> 7);

        // Clamp drive to +/-1000
        if (i_current > I_LIMIT) begin
            i_clamp = I_LIMIT;
        end else if (i_current < -I_LIMIT) begin
            i_clamp = -I_LIMIT;
        end else begin
            i_clamp = i_current;
        end

        dv_w = quad_w + (48'sd5 * v_w) + DV_CONST - u_w
             + (48'(i_clamp) <<< `NEURON_FRAC);
        // a (b v - u)
        du_w = ((v_w >>> `IZH_B_SHIFT) - u_w) >>> `IZH_A_SHIFT;

        // Forward Euler, dt = 1/16 ms
        v_new = v_w + (dv_w >>> `IZH_DT_SHIFT);
        u_new = u_w + (du_w >>> `IZH_DT_SHIFT);

        // Keep v inside 18 bits
        if (v_new > V_MAX) begin
            v_sat = 18'sh1FFFF;
        end else if (v_new < V_MIN) begin
            v_sat = 18'sh20000;
        end else begin
            v_sat = v_new[17:0];
        end

        fire = (v_sat >= `IZH_VPEAK);

        // After-spike reset of v, kick to u
        if (fire) begin
            state_next.v_mem = `IZH_C;
            state_next.u_rec = u_new[17:0] + `IZH_D;
        end else begin
            state_next.v_mem = v_sat;
            state_next.u_rec = u_new[17:0];
        end
    end

    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            state_q.v_mem <= `IZH_V_INIT;
            state_q.u_rec <= `IZH_U_INIT;
            spike_q.spike <= 1'b0;
            spike_q.spkid <= 16'd0;
        end else begin
            state_q       <= state_next;
            spike_q.spike <= fire;
            // Id wraps at 16 bits
            if (fire) begin
                spike_q.spkid <= spike_q.spkid + 16'd1;
            end
        end
    end

    assign state_out  = state_q;
    assign spike_info = spike_q;

endmodule

// File: lfsr_noise.sv
`timescale 1ns/1ps
`include "neuron_consts.svh"

module lfsr_noise (
    input  logic                    neuron_clk,
    input  logic                    reset_sim,
    output neuron_pkg::float_word_t f_noise
);
    import neuron_pkg::*;

    // LFSR start word
    localparam logic [31:0] SEED_WORD = `NOISE_SEED;

    logic [31:0] lfsr_q;
    logic [31:0] lfsr_next;
    logic        feedback;
    float_word_t noise_next;
    float_word_t noise_q;

    // Taps 32, 22, 2, 1 into bit 0
    assign feedback  = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    assign lfsr_next = {lfsr_q[30:0], feedback};

    // Sign 0, exponent 127, low 20 mantissa bits random
    assign noise_next.bits = {12'h3F8, lfsr_next[19:0]};

    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            lfsr_q       <= SEED_WORD;
            noise_q.bits <= {12'h3F8, SEED_WORD[19:0]};
        end else begin
            lfsr_q  <= lfsr_next;
            noise_q <= noise_next;
        end
    end

    assign f_noise = noise_q;

endmodule

// File: neuron_consts.svh
`ifndef NEURON_CONSTS_SVH
`define NEURON_CONSTS_SVH

// Fixed-point format of v and u, Q8 millivolts
`define NEURON_FRAC 8

// Euler step of 1/16 ms as a right shift
`define IZH_DT_SHIFT 4

// Recovery time scale a = 1/64
`define IZH_A_SHIFT 6
// Recovery sensitivity b = 1/4
`define IZH_B_SHIFT 2

// Reset potential and recovery kick, Q8
`define IZH_C (-18'sd16640)
`define IZH_D (18'sd2048)
// Spike cutoff at +30 mV
`define IZH_VPEAK (18'sd7680)

// Start at rest
`define IZH_V_INIT `IZH_C
`define IZH_U_INIT (-18'sd3328)

// Noise LFSR start state, must be nonzero
`define NOISE_SEED 32'h1D87_2B41

`endif

// File: neuron_pkg.sv
package neuron_pkg;

    //////////////////////////////////////////////////////////////////////
    // IEEE-754 single precision word
    //////////////////////////////////////////////////////////////////////

    // Field view of a float
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] mant;
    } float_fields_t;

    // Same 32 bits, seen raw or decoded
    typedef union packed {
        logic [31:0]   bits;
        float_fields_t f;
    } float_word_t;

    //////////////////////////////////////////////////////////////////////
    // Motoneuron state and spike output
    //////////////////////////////////////////////////////////////////////

    // Membrane potential and recovery, both Q8 mV
    typedef struct packed {
        logic signed [17:0] v_mem;
        logic signed [17:0] u_rec;
    } neuron_state_t;

    // One-cycle spike pulse plus running spike id
    typedef struct packed {
        logic        spike;
        logic [15:0] spkid;
    } spike_out_t;

endpackage

// File: neuron_pool.sv
`timescale 1ns/1ps

module neuron_pool (
    input  logic                      neuron_clk,
    input  logic                      reset_sim,
    input  neuron_pkg::float_word_t   f_rawfr_ia,
    input  neuron_pkg::float_word_t   f_pps_coef_ia,
    output neuron_pkg::spike_out_t    spike_info,
    output logic signed [31:0]        i_current,
    output neuron_pkg::neuron_state_t state_out,
    output neuron_pkg::float_word_t   f_noise
);
    import neuron_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Ia afferent side
    //////////////////////////////////////////////////////////////////////

    // Scaled Ia rate, one edge after the inputs
    float_word_t f_scaled;

    // Random gain in [1,2), also brought out for debug
    lfsr_noise u_noise (
        .neuron_clk (neuron_clk),
        .reset_sim  (reset_sim),
        .f_noise    (f_noise)
    );

    pps_scaler u_pps (
        .neuron_clk    (neuron_clk),
        .reset_sim     (reset_sim),
        .f_rawfr_ia    (f_rawfr_ia),
        .f_pps_coef_ia (f_pps_coef_ia),
        .f_scaled      (f_scaled)
    );

    // Integer current, two edges after the inputs
    current_mixer u_mixer (
        .neuron_clk (neuron_clk),
        .reset_sim  (reset_sim),
        .f_scaled   (f_scaled),
        .f_noise    (f_noise),
        .i_current  (i_current)
    );

    //////////////////////////////////////////////////////////////////////
    // Motoneuron
    //////////////////////////////////////////////////////////////////////

    izneuron u_mn (
        .neuron_clk (neuron_clk),
        .reset_sim  (reset_sim),
        .i_current  (i_current),
        .spike_info (spike_info),
        .state_out  (state_out)
    );

endmodule

// File: neuron_pool_tb.sv
`timescale 1ns/1ps
`include "neuron_consts.svh"

module neuron_pool_tb;
    import neuron_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int NOISE_CYCLES = 200;
    localparam int ZERO_CYCLES  = 400;
    localparam int CUR_CYCLES   = 300;
    localparam int SPIKE_CYCLES = 2000;
    localparam int NEG_CYCLES   = 300;
    // All test lengths plus reset and settling margin
    localparam int WATCHDOG_CYCLES = NOISE_CYCLES + ZERO_CYCLES + CUR_CYCLES
                                   + SPIKE_CYCLES + NEG_CYCLES + 100;

    logic               neuron_clk;
    logic               reset_sim;
    float_word_t        f_rawfr_ia;
    float_word_t        f_pps_coef_ia;
    spike_out_t         spike_info;
    logic signed [31:0] i_current;
    neuron_state_t      state_out;
    float_word_t        f_noise;

    // Model pipeline state after the latest rising edge
    logic [31:0]        m_lfsr;
    logic [31:0]        m_noise;
    logic [31:0]        m_scaled;
    logic signed [31:0] m_cur;
    logic signed [17:0] m_v;
    logic signed [17:0] m_u;
    logic               m_spike;
    logic [15:0]        m_spkid;

    logic [15:0] rng;
    int          err_total    = 0;
    int          spikes_seen  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    tb_clock u_clock (.neuron_clk(neuron_clk), .reset_sim(reset_sim));

    neuron_pool UUT (
        .neuron_clk    (neuron_clk),
        .reset_sim     (reset_sim),
        .f_rawfr_ia    (f_rawfr_ia),
        .f_pps_coef_ia (f_pps_coef_ia),
        .spike_info    (spike_info),
        .i_current     (i_current),
        .state_out     (state_out),
        .f_noise       (f_noise)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference models
    //////////////////////////////////////////////////////////////////////

    // Stimulus source is a 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] rng_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Noise generator with taps 32 22 2 1 into bit 0
    function automatic logic [31:0] noise_lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Truncating single-precision product
    function automatic logic [31:0] fmul_ref(input logic [31:0] a, input logic [31:0] b);
        logic [47:0] p;
        int          e;
        logic [22:0] m;
        if (a[30:23] == 8'd0 || b[30:23] == 8'd0) begin
            return 32'd0;
        end
        p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
        e = int'(a[30:23]) + int'(b[30:23]) - 127;
        if (p[47]) begin
            m = p[46:24];
            e = e + 1;
        end else begin
            m = p[45:23];
        end
        // Underflow flushes
        if (e <= 0) begin
            return 32'd0;
        end
        return {a[31] ^ b[31], e[7:0], m};
    endfunction

    // Float to int32 toward minus infinity
    function automatic logic signed [31:0] floor_ref(input logic [31:0] w);
        int     e;
        longint sig;
        longint mag;
        logic   frac;
        e   = int'(w[30:23]) - 127;
        sig = longint'({1'b1, w[22:0]});
        if (w[30:23] == 8'd0) begin
            return 32'sd0;
        end else if (e < 0) begin
            return w[31] ? -32'sd1 : 32'sd0;
        end else if (e >= 31) begin
            return w[31] ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
        end
        mag  = (e >= 23) ? (sig << (e - 23)) : (sig >> (23 - e));
        frac = (e < 23) && ((sig & ((longint'(1) << (23 - e)) - 1)) != 0);
        return w[31] ? 32'(-mag - longint'(frac)) : 32'(mag);
    endfunction

    // One Euler step of the Q8 neuron that returns the spike flag
    function automatic logic izh_step(input logic signed [17:0] v, input logic signed [17:0] u,
                                      input logic signed [31:0] cur,
                                      output logic signed [17:0] v_n,
                                      output logic signed [17:0] u_n);
        longint      vl;
        longint      ul;
        longint      q;
        longint      ic;
        longint      dv;
        longint      vn;
        logic [17:0] u18;
        logic        fire;
        vl = longint'(v);
        ul = longint'(u);
        q  = (vl * vl) >>> `NEURON_FRAC;
        ic = (cur > 1000) ? 64'sd1000 : ((cur < -1000) ? -64'sd1000 : longint'(cur));
        dv = (q >>> 5) + (q >>> 7) + 5 * vl + (64'sd140 <<< `NEURON_FRAC) - ul
           + (ic <<< `NEURON_FRAC);
        vn = vl + (dv >>> `IZH_DT_SHIFT);
        vn = (vn > 131071) ? 64'sd131071 : ((vn < -131072) ? -64'sd131072 : vn);
        // u wraps at 18 bits while v saturates
        u18  = 18'(ul + ((((vl >>> `IZH_B_SHIFT) - ul) >>> `IZH_A_SHIFT) >>> `IZH_DT_SHIFT));
        fire = (vn >= longint'(`IZH_VPEAK));
        v_n  = fire ? `IZH_C : 18'(vn);
        u_n  = fire ? $signed(u18 + 18'(`IZH_D)) : $signed(u18);
        return fire;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checking and stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [35:0] exp, input logic [35:0] got);
        if (exp !== got) begin
            $display("Fail %s: expected %h, got %h", name, exp, got);
            err_total++;
        end
    endtask

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = 32'd0;
        for (int k = 0; k < n; k++) begin
            rng = rng_step(rng);
            val = {val[30:0], rng[0]};
        end
    endtask

    task automatic rand_float(input logic neg, input int exp_lo, input int exp_span,
                              output logic [31:0] w);
        logic [31:0] e;
        logic [31:0] m;
        rand_bits(8, e);
        rand_bits(23, m);
        w = {neg, 8'(exp_lo + (int'(e) % exp_span)), m[22:0]};
    endtask

    // New inputs land just after the edge
    task automatic drive(input logic [31:0] rate, input logic [31:0] coef);
        @(posedge neuron_clk);
        f_rawfr_ia.bits    <= rate;
        f_pps_coef_ia.bits <= coef;
    endtask

    task automatic settle();
        @(negedge neuron_clk);
        #1;
    endtask

    task automatic end_test(input string name, input int base_err);
        if (err_total == base_err) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, err_total - base_err);
        end
    endtask

    // Comparator samples on the falling edge where outputs are stable
    always @(negedge neuron_clk) begin
        logic signed [17:0] nv;
        logic signed [17:0] nu;
        logic               fire;
        if (reset_sim !== 1'b0) begin
            m_lfsr   = `NOISE_SEED;
            m_noise  = {12'h3F8, m_lfsr[19:0]};
            m_scaled = 32'd0;
            m_cur    = 32'sd0;
            m_v      = `IZH_V_INIT;
            m_u      = `IZH_U_INIT;
            m_spike  = 1'b0;
            m_spkid  = 16'd0;
        end else begin
            check_value("f_noise", {4'd0, m_noise}, {4'd0, f_noise.bits});
            check_value("i_current", {4'd0, m_cur}, {4'd0, i_current});
            check_value("state_out", {m_v, m_u}, state_out);
            check_value("spike", {35'd0, m_spike}, {35'd0, spike_info.spike});
            check_value("spkid", {20'd0, m_spkid}, {20'd0, spike_info.spkid});
            if (spike_info.spike) begin
                spikes_seen++;
            end
            // Advance every stage from the old values as registers do
            fire     = izh_step(m_v, m_u, m_cur, nv, nu);
            m_cur    = floor_ref(fmul_ref(m_scaled, m_noise));
            m_scaled = fmul_ref(f_rawfr_ia.bits, f_pps_coef_ia.bits);
            m_lfsr   = noise_lfsr_next(m_lfsr);
            m_noise  = {12'h3F8, m_lfsr[19:0]};
            m_v      = nv;
            m_u      = nu;
            m_spike  = fire;
            m_spkid  = m_spkid + {15'd0, fire};
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] c;
        logic [31:0] z;
        logic [31:0] seed_word;
        logic [15:0] base_id;
        int          base_err;
        int          base_spk;
        rng                = 16'd10173;
        seed_word          = `NOISE_SEED;
        f_rawfr_ia.bits    = 32'd0;
        f_pps_coef_ia.bits = 32'd0;
        @(negedge reset_sim);

        // Values straight out of reset
        base_err = err_total;
        settle();
        check_value("spike", 36'd0, {35'd0, spike_info.spike});
        check_value("spkid", 36'd0, {20'd0, spike_info.spkid});
        check_value("i_current", 36'd0, {4'd0, i_current});
        check_value("f_noise", {4'd0, 12'h3F8, seed_word[19:0]}, {4'd0, f_noise.bits});
        check_value("state_out", {`IZH_V_INIT, `IZH_U_INIT}, state_out);
        end_test("reset values", base_err);

        base_err = err_total;
        repeat (NOISE_CYCLES) drive(32'd0, 32'd0);
        end_test("noise sequence", base_err);

        // Neuron relaxes toward rest, no firing expected
        base_err = err_total;
        base_spk = spikes_seen;
        repeat (ZERO_CYCLES) drive(32'd0, 32'd0);
        settle();
        check_value("i_current", 36'd0, {4'd0, i_current});
        if (spikes_seen != base_spk) begin
            $display("Zero drive produced %0d spikes", spikes_seen - base_spk);
            err_total++;
        end
        end_test("zero drive", base_err);

        // Moderate rates and coefficients with a few zero words
        base_err = err_total;
        repeat (CUR_CYCLES) begin
            rand_bits(3, z);
            rand_float(1'b0, 120, 15, r);
            r = (z == 32'd0) ? 32'd0 : r;
            rand_bits(3, z);
            rand_float(1'b0, 120, 15, c);
            c = (z == 32'd0) ? 32'd0 : c;
            drive(r, c);
        end
        end_test("current path", base_err);

        // Rate 80.0 times coefficient 1.0 keeps the cell firing
        base_err = err_total;
        settle();
        base_spk = spikes_seen;
        base_id  = spike_info.spkid;
        repeat (SPIKE_CYCLES) drive(32'h42A0_0000, 32'h3F80_0000);
        settle();
        if (spikes_seen - base_spk < 10) begin
            $display("Spiking test saw only %0d spikes", spikes_seen - base_spk);
            err_total++;
        end
        check_value("spkid", {20'd0, base_id + 16'(spikes_seen - base_spk)},
                    {20'd0, spike_info.spkid});
        end_test("spiking and id", base_err);

        // Inhibitory coefficients with some rates large enough to saturate
        base_err = err_total;
        repeat (NEG_CYCLES) begin
            rand_bits(1, z);
            rand_float(1'b0, z[0] ? 150 : 127, z[0] ? 16 : 8, r);
            rand_float(1'b1, 120, 15, c);
            drive(r, c);
        end
        end_test("negative and saturated current", base_err);

        settle();
        $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, err_total);
        if (tests_failed == 0 && err_total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: pps_scaler.sv
`timescale 1ns/1ps

module pps_scaler (
    input  logic                    neuron_clk,
    input  logic                    reset_sim,
    input  neuron_pkg::float_word_t f_rawfr_ia,
    input  neuron_pkg::float_word_t f_pps_coef_ia,
    output neuron_pkg::float_word_t f_scaled
);
    import neuron_pkg::*;

    float_word_t prod;
    float_word_t scaled_q;

    // Presynaptic inhibition scales the raw Ia rate
    float_mult u_mult (
        .x       (f_rawfr_ia),
        .y       (f_pps_coef_ia),
        .product (prod)
    );

    // First pipeline stage of the afferent path
    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            scaled_q.bits <= 32'd0;
        end else begin
            scaled_q <= prod;
        end
    end

    assign f_scaled = scaled_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the neuron_pool testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module neuron_pool_tb -o neuron_pool_sim
./obj_dir/neuron_pool_sim > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic neuron_clk,
    output logic reset_sim
);

    // Free running 20 ns clock
    initial begin
        neuron_clk = 1'b0;
        forever #HALF_PERIOD neuron_clk = ~neuron_clk;
    end

    // Reset held over the first rising edges, released on an edge
    initial begin
        reset_sim = 1'b1;
        repeat (RESET_CYCLES) @(posedge neuron_clk);
        reset_sim <= 1'b0;
    end

endmodule
